/* rtl/simple_sys_pkg.sv */
// Device map, register offsets and device select type
// for the simple bus-based system

`default_nettype none

package simple_sys_pkg;

  // Selected device on the shared bus
  typedef enum logic [1:0] {
    DevRam,
    DevSimCtrl,
    DevTimer,
    DevNone
  } dev_sel_e;

  // Device windows, compared under the mask
  localparam logic [31:0] RamBase     = 32'h0010_0000;
  localparam logic [31:0] RamMask     = ~32'h000F_FFFF; // 1 MB
  localparam logic [31:0] SimCtrlBase = 32'h0002_0000;
  localparam logic [31:0] SimCtrlMask = ~32'h0000_03FF; // 1 kB
  localparam logic [31:0] TimerBase   = 32'h0003_0000;
  localparam logic [31:0] TimerMask   = ~32'h0000_03FF; // 1 kB

  // Timer registers
  localparam logic [31:0] TimerMtimeLo = 32'h0000_0000;
  localparam logic [31:0] TimerMtimeHi = 32'h0000_0004;
  localparam logic [31:0] TimerCmpLo   = 32'h0000_0008;
  localparam logic [31:0] TimerCmpHi   = 32'h0000_000C;

  // Simulation control registers
  localparam logic [31:0] SimCharOffs = 32'h0000_0000;
  localparam logic [31:0] SimHaltOffs = 32'h0000_0008;

endpackage

`default_nettype wire

/* rtl/wb_if.sv */
// Wishbone classic link with host and device modports

`timescale 1ns/1ps
`default_nettype none

interface wb_if (
  input logic clk_i
);

  // Request side, driven by the host
  logic        cyc;
  logic        stb;
  logic        we;
  logic [3:0]  sel;
  logic [31:0] adr;
  logic [31:0] dat_w;

  // Response side, driven by the device
  logic [31:0] dat_r;
  logic        ack;
  logic        err;

  modport host (
    input  clk_i,
    output cyc, stb, we, sel, adr, dat_w,
    input  dat_r, ack, err
  );

  modport device (
    input  clk_i,
    input  cyc, stb, we, sel, adr, dat_w,
    output dat_r, ack, err
  );

endinterface

`default_nettype wire

/* rtl/bus_ctrl.sv */
// Address decoder and response mux for one host and three devices
// Unmapped accesses get a registered one-cycle error

`timescale 1ns/1ps
`default_nettype none

module bus_ctrl (
  input logic  clk_i,
  input logic  rst_n_i,
  wb_if.device host_i,
  wb_if.host   ram_o,
  wb_if.host   tmr_o,
  wb_if.host   sim_o
);

  simple_sys_pkg::dev_sel_e dev_sel;
  logic                     dec_err_q;

  // Device select from base and mask
  always_comb begin
    dev_sel = simple_sys_pkg::DevNone;
    if ((host_i.adr & simple_sys_pkg::RamMask) == simple_sys_pkg::RamBase) begin
      dev_sel = simple_sys_pkg::DevRam;
    end else if ((host_i.adr & simple_sys_pkg::SimCtrlMask) == simple_sys_pkg::SimCtrlBase) begin
      dev_sel = simple_sys_pkg::DevSimCtrl;
    end else if ((host_i.adr & simple_sys_pkg::TimerMask) == simple_sys_pkg::TimerBase) begin
      dev_sel = simple_sys_pkg::DevTimer;
    end
  end

  // Only the selected device sees cyc and stb
  assign ram_o.cyc   = host_i.cyc & (dev_sel == simple_sys_pkg::DevRam);
  assign ram_o.stb   = host_i.stb & (dev_sel == simple_sys_pkg::DevRam);
  assign ram_o.we    = host_i.we;
  assign ram_o.sel   = host_i.sel;
  assign ram_o.adr   = host_i.adr;
  assign ram_o.dat_w = host_i.dat_w;

  assign tmr_o.cyc   = host_i.cyc & (dev_sel == simple_sys_pkg::DevTimer);
  assign tmr_o.stb   = host_i.stb & (dev_sel == simple_sys_pkg::DevTimer);
  assign tmr_o.we    = host_i.we;
  assign tmr_o.sel   = host_i.sel;
  assign tmr_o.adr   = host_i.adr;
  assign tmr_o.dat_w = host_i.dat_w;

  assign sim_o.cyc   = host_i.cyc & (dev_sel == simple_sys_pkg::DevSimCtrl);
  assign sim_o.stb   = host_i.stb & (dev_sel == simple_sys_pkg::DevSimCtrl);
  assign sim_o.we    = host_i.we;
  assign sim_o.sel   = host_i.sel;
  assign sim_o.adr   = host_i.adr;
  assign sim_o.dat_w = host_i.dat_w;

  // Decode error, answered once per held strobe
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dec_err_q <= 1'b0;
    end else begin
      dec_err_q <= host_i.cyc & host_i.stb & ~dec_err_q &
                   (dev_sel == simple_sys_pkg::DevNone);
    end
  end

  // Response mux
  always_comb begin
    case (dev_sel)
      simple_sys_pkg::DevRam: begin
        host_i.dat_r = ram_o.dat_r;
        host_i.ack   = ram_o.ack;
        host_i.err   = ram_o.err;
      end
      simple_sys_pkg::DevTimer: begin
        host_i.dat_r = tmr_o.dat_r;
        host_i.ack   = tmr_o.ack;
        host_i.err   = tmr_o.err;
      end
      simple_sys_pkg::DevSimCtrl: begin
        host_i.dat_r = sim_o.dat_r;
        host_i.ack   = sim_o.ack;
        host_i.err   = sim_o.err;
      end
      default: begin
        host_i.dat_r = '0;
        host_i.ack   = 1'b0;
        host_i.err   = dec_err_q;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/ram_wb.sv */
// Word RAM with byte enables on a Wishbone device port
// Aliases within its address window

`timescale 1ns/1ps
`default_nettype none

module ram_wb #(
  parameter int unsigned RamDepth = 1024
) (
  input logic  clk_i,
  input logic  rst_n_i,
  wb_if.device bus_i
);

  localparam int unsigned AddrW = $clog2(RamDepth);

  logic [31:0]      mem [RamDepth];
  logic [AddrW-1:0] word_idx;
  logic             req;
  logic             ack_q;
  logic [31:0]      rdata_q;

  // Word index wraps at the RAM depth
  assign word_idx = bus_i.adr[AddrW+1:2];
  assign req      = bus_i.cyc & bus_i.stb & ~ack_q;

  always_ff @(posedge clk_i) begin
    if (req) begin
      if (bus_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (bus_i.sel[b]) begin
            mem[word_idx][8*b +: 8] <= bus_i.dat_w[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  assign bus_i.dat_r = rdata_q;
  assign bus_i.ack   = ack_q;
  assign bus_i.err   = 1'b0;

endmodule

`default_nettype wire

/* rtl/timer_wb.sv */
// 64-bit time counter with prescaler and compare interrupt
// Registers are accessed as 32-bit halves with byte enables

`timescale 1ns/1ps
`default_nettype none

module timer_wb #(
  parameter int unsigned TimerPrescale = 4
) (
  input logic   clk_i,
  input logic   rst_n_i,
  wb_if.device  bus_i,
  output logic  irq_o
);

  localparam int unsigned PreW = (TimerPrescale > 1) ? $clog2(TimerPrescale) : 1;

  logic [PreW-1:0] pre_cnt_q;
  logic            tick;
  logic [63:0]     mtime_q;
  logic [63:0]     mtimecmp_q;
  logic            ack_q;
  logic            err_q;
  logic            irq_q;
  logic [31:0]     rdata_q;
  logic [31:0]     offs;
  logic [31:0]     wmask;
  logic [31:0]     reg_rd;
  logic            req;
  logic            hit;
  logic            wr;

  assign offs  = {22'd0, bus_i.adr[9:2], 2'b00};
  assign wmask = {{8{bus_i.sel[3]}}, {8{bus_i.sel[2]}}, {8{bus_i.sel[1]}}, {8{bus_i.sel[0]}}};
  assign req   = bus_i.cyc & bus_i.stb & ~ack_q & ~err_q;
  assign wr    = req & bus_i.we & hit;
  assign tick  = (pre_cnt_q == PreW'(TimerPrescale - 1));

  // Register read and offset check
  always_comb begin
    hit    = 1'b1;
    reg_rd = '0;
    case (offs)
      simple_sys_pkg::TimerMtimeLo: reg_rd = mtime_q[31:0];
      simple_sys_pkg::TimerMtimeHi: reg_rd = mtime_q[63:32];
      simple_sys_pkg::TimerCmpLo:   reg_rd = mtimecmp_q[31:0];
      simple_sys_pkg::TimerCmpHi:   reg_rd = mtimecmp_q[63:32];
      default:                      hit    = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pre_cnt_q  <= '0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      irq_q      <= 1'b0;
      ack_q      <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      pre_cnt_q <= tick ? '0 : pre_cnt_q + 1'b1;
      // A write to a time half takes priority over the count
      if (wr && offs == simple_sys_pkg::TimerMtimeLo) begin
        mtime_q[31:0] <= (mtime_q[31:0] & ~wmask) | (bus_i.dat_w & wmask);
      end else if (wr && offs == simple_sys_pkg::TimerMtimeHi) begin
        mtime_q[63:32] <= (mtime_q[63:32] & ~wmask) | (bus_i.dat_w & wmask);
      end else if (tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (wr && offs == simple_sys_pkg::TimerCmpLo) begin
        mtimecmp_q[31:0] <= (mtimecmp_q[31:0] & ~wmask) | (bus_i.dat_w & wmask);
      end
      if (wr && offs == simple_sys_pkg::TimerCmpHi) begin
        mtimecmp_q[63:32] <= (mtimecmp_q[63:32] & ~wmask) | (bus_i.dat_w & wmask);
      end
      irq_q <= (mtime_q >= mtimecmp_q);
      ack_q <= req & hit;
      err_q <= req & ~hit;
    end
  end

  // Read data
  always_ff @(posedge clk_i) begin
    if (req && !bus_i.we) begin
      rdata_q <= reg_rd;
    end
  end

  assign bus_i.dat_r = rdata_q;
  assign bus_i.ack   = ack_q;
  assign bus_i.err   = err_q;
  assign irq_o       = irq_q;

endmodule

`default_nettype wire

/* rtl/sim_ctrl_wb.sv */
// Simulation control device with character output and sticky halt

`timescale 1ns/1ps
`default_nettype none

module sim_ctrl_wb (
  input logic        clk_i,
  input logic        rst_n_i,
  wb_if.device       bus_i,
  output logic       char_valid_o,
  output logic [7:0] char_o,
  output logic       halt_o
);

  logic [31:0] offs;
  logic        req;
  logic        is_char;
  logic        is_halt;
  logic        ack_q;
  logic        err_q;
  logic        halt_q;
  logic        char_valid_q;
  logic [7:0]  char_q;
  logic [31:0] rdata_q;

  assign offs    = {22'd0, bus_i.adr[9:2], 2'b00};
  assign is_char = (offs == simple_sys_pkg::SimCharOffs);
  assign is_halt = (offs == simple_sys_pkg::SimHaltOffs);
  assign req     = bus_i.cyc & bus_i.stb & ~ack_q & ~err_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q        <= 1'b0;
      err_q        <= 1'b0;
      halt_q       <= 1'b0;
      char_valid_q <= 1'b0;
    end else begin
      ack_q        <= req & (is_char | is_halt);
      err_q        <= req & ~(is_char | is_halt);
      // Pulse lines up with the ack of the write
      char_valid_q <= req & bus_i.we & is_char & bus_i.sel[0];
      if (req && bus_i.we && is_halt && bus_i.sel[0] && bus_i.dat_w[0]) begin
        halt_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req && bus_i.we && is_char && bus_i.sel[0]) begin
      char_q <= bus_i.dat_w[7:0];
    end
    if (req && !bus_i.we) begin
      rdata_q <= is_halt ? {31'd0, halt_q} : 32'd0;
    end
  end

  assign bus_i.dat_r  = rdata_q;
  assign bus_i.ack    = ack_q;
  assign bus_i.err    = err_q;
  assign char_valid_o = char_valid_q;
  assign char_o       = char_q;
  assign halt_o       = halt_q;

endmodule

`default_nettype wire

/* rtl/simple_system.sv */
// Top level with host Wishbone ports, bus controller,
// RAM, timer and simulation control

`timescale 1ns/1ps
`default_nettype none

module simple_system #(
  parameter int unsigned RamDepth      = 1024,
  parameter int unsigned TimerPrescale = 4
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [3:0]  wb_sel_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_err_o,
  output logic        timer_irq_o,
  output logic        char_valid_o,
  output logic [7:0]  char_o,
  output logic        halt_o
);

  wb_if host_bus (.clk_i(clk_i));
  wb_if ram_bus  (.clk_i(clk_i));
  wb_if tmr_bus  (.clk_i(clk_i));
  wb_if sim_bus  (.clk_i(clk_i));

  // Host ports onto the host-side link
  assign host_bus.cyc   = wb_cyc_i;
  assign host_bus.stb   = wb_stb_i;
  assign host_bus.we    = wb_we_i;
  assign host_bus.sel   = wb_sel_i;
  assign host_bus.adr   = wb_adr_i;
  assign host_bus.dat_w = wb_dat_i;
  assign wb_dat_o       = host_bus.dat_r;
  assign wb_ack_o       = host_bus.ack;
  assign wb_err_o       = host_bus.err;

  bus_ctrl i_bus_ctrl (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .host_i  (host_bus.device),
    .ram_o   (ram_bus.host),
    .tmr_o   (tmr_bus.host),
    .sim_o   (sim_bus.host)
  );

  ram_wb #(
    .RamDepth (RamDepth)
  ) i_ram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus_i   (ram_bus.device)
  );

  timer_wb #(
    .TimerPrescale (TimerPrescale)
  ) i_timer (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus_i   (tmr_bus.device),
    .irq_o   (timer_irq_o)
  );

  sim_ctrl_wb i_sim_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .bus_i        (sim_bus.device),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .halt_o       (halt_o)
  );

endmodule

`default_nettype wire

/* verification/simple_system_checker.sv */
// Handshake and reset assertions for the host port of simple_system
// Bound into every simple_system instance

`timescale 1ns/1ps
`default_nettype none

module simple_system_checker (
  input logic clk_i,
  input logic rst_n_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_o,
  input logic wb_err_o,
  input logic timer_irq_o,
  input logic char_valid_o,
  input logic halt_o
);

  // Failed assertions so far, watched by the testbench
  int unsigned fail_cnt = 0;

  // Response exactly one cycle after a new strobe
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_cyc_i && $rose(wb_stb_i) |=> wb_ack_o || wb_err_o)
    else begin
      $error("no ack or err one cycle after stb");
      fail_cnt++;
    end

  // Responses are single-cycle pulses
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_ack_o || wb_err_o |=> !wb_ack_o && !wb_err_o)
    else begin
      $error("response pulse longer than one cycle");
      fail_cnt++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) !(wb_ack_o && wb_err_o))
    else begin
      $error("ack and err high together");
      fail_cnt++;
    end

  // All outputs cleared by reset
  assert property (@(posedge clk_i)
    !rst_n_i |=> !wb_ack_o && !wb_err_o && !timer_irq_o && !char_valid_o && !halt_o)
    else begin
      $error("outputs not low after reset");
      fail_cnt++;
    end

  // Character strobe only with the ack of its write
  assert property (@(posedge clk_i) disable iff (!rst_n_i) char_valid_o |-> wb_ack_o)
    else begin
      $error("char_valid_o without ack");
      fail_cnt++;
    end

endmodule

bind simple_system simple_system_checker i_checker (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .wb_cyc_i     (wb_cyc_i),
  .wb_stb_i     (wb_stb_i),
  .wb_ack_o     (wb_ack_o),
  .wb_err_o     (wb_err_o),
  .timer_irq_o  (timer_irq_o),
  .char_valid_o (char_valid_o),
  .halt_o       (halt_o)
);

`default_nettype wire

/* verification/simple_system_tb.sv */
// Testbench for simple_system with Wishbone host task, RAM shadow,
// timer, character and halt checks

`timescale 1ns/1ps
`default_nettype none

module simple_system_tb;

  localparam int unsigned RamDepth       = 1024;
  localparam int unsigned TimerPrescale  = 4;
  localparam int unsigned ClkPeriod      = 100;
  localparam int unsigned NumRamWords    = 16;
  localparam int unsigned NumRamWr       = 64;
  localparam int unsigned NumChars       = 6;
  localparam int unsigned ElapsedWait    = 40;
  localparam int unsigned IrqLimit       = 20 * TimerPrescale + 4;
  localparam int unsigned NumTrans       = 2 * NumRamWords + NumRamWr + 40;
  localparam int unsigned WatchdogCycles = NumTrans * 4 + ElapsedWait + IrqLimit + 100;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [3:0]  wb_sel;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        wb_err;
  logic        timer_irq;
  logic        char_valid;
  logic [7:0]  char_val;
  logic        halt;

  logic [31:0] lcg_state = 32'ha0d9;
  logic [31:0] shadow [RamDepth];
  logic [7:0]  seen_chars [$];
  logic [7:0]  exp_chars [$];
  int unsigned cycle_cnt = 0;

  simple_system #(
    .RamDepth      (RamDepth),
    .TimerPrescale (TimerPrescale)
  ) i_simple_system (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .wb_cyc_i     (wb_cyc),
    .wb_stb_i     (wb_stb),
    .wb_we_i      (wb_we),
    .wb_sel_i     (wb_sel),
    .wb_adr_i     (wb_adr),
    .wb_dat_i     (wb_dat_w),
    .wb_dat_o     (wb_dat_r),
    .wb_ack_o     (wb_ack),
    .wb_err_o     (wb_err),
    .timer_irq_o  (timer_irq),
    .char_valid_o (char_valid),
    .char_o       (char_val),
    .halt_o       (halt)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // Character strobes, sampled mid-cycle
  always @(negedge clk) begin
    if (char_valid) begin
      seen_chars.push_back(char_val);
    end
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Simulation timed out before all tests finished");
    $display("Errors found");
    $fatal(1);
  end

  initial begin
    wait (i_simple_system.i_checker.fail_cnt != 0);
    $display("A bound handshake assertion failed");
    $display("Errors found");
    $fatal(1);
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int unsigned ram_index(input logic [31:0] adr);
    return (adr >> 2) % RamDepth;
  endfunction

  // Word idx seen through a random alias inside the 1 MB window
  function automatic logic [31:0] ram_alias_adr(input int unsigned idx, input logic [31:0] r);
    return simple_sys_pkg::RamBase | (r & ~simple_sys_pkg::RamMask & ~32'(RamDepth * 4 - 1)) |
           32'(idx << 2);
  endfunction

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    assert (got === exp) else begin
      $display("ERROR %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  // Single Wishbone classic transfer; stb is low for one cycle before it
  task automatic bus_xfer(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                          input logic [31:0] wdata, input logic exp_err,
                          output logic [31:0] rdata);
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_sel   = sel;
    wb_adr   = adr;
    wb_dat_w = wdata;
    do begin
      @(posedge clk);
      #1;
    end while (!(wb_ack || wb_err));
    rdata = wb_dat_r;
    check_eq({wb_ack, wb_err}, exp_err ? 2'b01 : 2'b10, $sformatf("response kind at %h", adr));
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  initial begin : stimulus
    logic [31:0] rdata;
    logic [31:0] adr;
    logic [31:0] data;
    logic [31:0] r;
    logic [31:0] prev;
    logic [31:0] target;
    logic [3:0]  sel;
    int unsigned idx;
    int unsigned cyc_w;
    int unsigned elapsed;
    int unsigned waited;

    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_sel   = 4'h0;
    wb_adr   = 32'h0;
    wb_dat_w = 32'h0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_eq(timer_irq, 1'b0, "timer_irq_o after reset");
    check_eq(halt, 1'b0, "halt_o after reset");

    // RAM: full-word preload, then random byte writes through aliases
    for (int i = 0; i < NumRamWords; i++) begin
      adr  = simple_sys_pkg::RamBase + 32'(i * 4);
      data = next_rand();
      bus_xfer(1'b1, adr, 4'hF, data, 1'b0, rdata);
      shadow[ram_index(adr)] = data;
    end
    for (int i = 0; i < NumRamWr; i++) begin
      r    = next_rand();
      idx  = next_rand() % NumRamWords;
      adr  = ram_alias_adr(idx, r);
      data = next_rand();
      sel  = 4'(next_rand() >> 28);
      bus_xfer(1'b1, adr, sel, data, 1'b0, rdata);
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) begin
          shadow[ram_index(adr)][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
    for (int i = 0; i < NumRamWords; i++) begin
      adr = ram_alias_adr(i, next_rand());
      bus_xfer(1'b0, adr, 4'hF, 32'h0, 1'b0, rdata);
      check_eq(rdata, shadow[ram_index(adr)], $sformatf("RAM read at %h", adr));
    end

    // Decode errors leave the RAM untouched
    bus_xfer(1'b1, 32'h0020_000C, 4'hF, next_rand(), 1'b1, rdata);
    bus_xfer(1'b0, 32'h0000_4000, 4'hF, 32'h0, 1'b1, rdata);
    bus_xfer(1'b0, simple_sys_pkg::TimerBase + 32'h10, 4'hF, 32'h0, 1'b1, rdata);
    bus_xfer(1'b1, simple_sys_pkg::SimCtrlBase + 32'h4, 4'hF, 32'h1, 1'b1, rdata);
    adr = simple_sys_pkg::RamBase + 32'hC;
    bus_xfer(1'b0, adr, 4'hF, 32'h0, 1'b0, rdata);
    check_eq(rdata, shadow[ram_index(adr)], "RAM word after unmapped write");

    // Timer counts up and is bounded by elapsed cycles
    prev = 32'h0;
    for (int i = 0; i < 4; i++) begin
      bus_xfer(1'b0, simple_sys_pkg::TimerBase + simple_sys_pkg::TimerMtimeLo, 4'hF, 32'h0,
               1'b0, rdata);
      check_eq(rdata >= prev, 1'b1, "mtime never decreases");
      prev = rdata;
    end
    bus_xfer(1'b1, simple_sys_pkg::TimerBase + simple_sys_pkg::TimerMtimeLo, 4'hF, 32'h0,
             1'b0, rdata);
    cyc_w = cycle_cnt;
    repeat (ElapsedWait) @(posedge clk);
    bus_xfer(1'b0, simple_sys_pkg::TimerBase + simple_sys_pkg::TimerMtimeLo, 4'hF, 32'h0,
             1'b0, rdata);
    elapsed = cycle_cnt - cyc_w;
    check_eq(rdata <= (elapsed + TimerPrescale - 1) / TimerPrescale, 1'b1,
             "mtime above elapsed cycles");
    check_eq(rdata + 1 >= elapsed / TimerPrescale, 1'b1, "mtime below elapsed cycles");

    // Compare 20 counts ahead
    bus_xfer(1'b0, simple_sys_pkg::TimerBase + simple_sys_pkg::TimerMtimeLo, 4'hF, 32'h0,
             1'b0, rdata);
    target = rdata + 32'd20;
    bus_xfer(1'b1, simple_sys_pkg::TimerBase + simple_sys_pkg::TimerCmpLo, 4'hF, target,
             1'b0, rdata);
    bus_xfer(1'b1, simple_sys_pkg::TimerBase + simple_sys_pkg::TimerCmpHi, 4'hF, 32'h0,
             1'b0, rdata);
    // Let the interrupt see the new compare value
    repeat (2) @(posedge clk);
    #1;
    check_eq(timer_irq, 1'b0, "timer_irq_o before compare reached");
    waited = 0;
    while (!timer_irq && waited < IrqLimit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    check_eq(timer_irq, 1'b1, "timer_irq_o after compare reached");
    bus_xfer(1'b0, simple_sys_pkg::TimerBase + simple_sys_pkg::TimerMtimeLo, 4'hF, 32'h0,
             1'b0, rdata);
    check_eq(rdata >= target, 1'b1, "mtime at interrupt");
    bus_xfer(1'b1, simple_sys_pkg::TimerBase + simple_sys_pkg::TimerCmpLo, 4'hF, '1,
             1'b0, rdata);
    bus_xfer(1'b1, simple_sys_pkg::TimerBase + simple_sys_pkg::TimerCmpHi, 4'hF, '1,
             1'b0, rdata);
    repeat (2) @(posedge clk);
    #1;
    check_eq(timer_irq, 1'b0, "timer_irq_o after compare reset");

    // Characters, one strobe per write with sel bit 0
    for (int i = 0; i < NumChars; i++) begin
      data = next_rand();
      sel  = 4'(next_rand() >> 28) | 4'b0001;
      bus_xfer(1'b1, simple_sys_pkg::SimCtrlBase + simple_sys_pkg::SimCharOffs, sel, data,
               1'b0, rdata);
      exp_chars.push_back(data[7:0]);
    end
    bus_xfer(1'b1, simple_sys_pkg::SimCtrlBase + simple_sys_pkg::SimCharOffs, 4'b1110,
             next_rand(), 1'b0, rdata);
    bus_xfer(1'b0, simple_sys_pkg::SimCtrlBase + simple_sys_pkg::SimCharOffs, 4'hF, 32'h0,
             1'b0, rdata);
    check_eq(rdata, 32'h0, "character register read");
    check_eq(seen_chars.size(), NumChars, "number of char_valid_o pulses");
    for (int i = 0; i < NumChars; i++) begin
      check_eq(seen_chars[i], exp_chars[i], $sformatf("character %0d", i));
    end

    // Sticky halt
    adr = simple_sys_pkg::SimCtrlBase + simple_sys_pkg::SimHaltOffs;
    bus_xfer(1'b1, adr, 4'hF, 32'h0, 1'b0, rdata);
    check_eq(halt, 1'b0, "halt_o after writing 0");
    bus_xfer(1'b1, adr, 4'hF, 32'h1, 1'b0, rdata);
    check_eq(halt, 1'b1, "halt_o after writing 1");
    bus_xfer(1'b0, adr, 4'hF, 32'h0, 1'b0, rdata);
    check_eq(rdata, 32'h1, "halt register read");
    bus_xfer(1'b1, adr, 4'hF, 32'h0, 1'b0, rdata);
    bus_xfer(1'b0, adr, 4'hF, 32'h0, 1'b0, rdata);
    check_eq(rdata, 32'h1, "halt register read after clearing attempt");
    check_eq(halt, 1'b1, "halt_o after writing 0 again");

    repeat (2) @(posedge clk);
    if (i_simple_system.i_checker.fail_cnt == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Errors found");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

/* sources.f */
rtl/simple_sys_pkg.sv
rtl/wb_if.sv
rtl/bus_ctrl.sv
rtl/ram_wb.sv
rtl/timer_wb.sv
rtl/sim_ctrl_wb.sv
rtl/simple_system.sv
verification/simple_system_checker.sv
verification/simple_system_tb.sv

/* Bender.yml */
package:
  name: simple_system

sources:
  # Design
  - files:
      - rtl/simple_sys_pkg.sv
      - rtl/wb_if.sv
      - rtl/bus_ctrl.sv
      - rtl/ram_wb.sv
      - rtl/timer_wb.sv
      - rtl/sim_ctrl_wb.sv
      - rtl/simple_system.sv

  # Verification
  - target: simulation
    files:
      - verification/simple_system_checker.sv
      - verification/simple_system_tb.sv
